/* common/memSysPkg.sv */
package memSysPkg;

  // One bus word of data
  typedef logic [31:0] wordT;

  // Byte address as seen by the processor and on the bus
  typedef logic [31:0] addrT;

  // Byte-lane enables for a store, bit n covers bits 8n+7..8n
  typedef logic [3:0] byteMaskT;

  // Current owner of the shared memory bus
  typedef enum logic [1:0] {
    ownNone,
    ownInstr,
    ownData
  } arbStateT;

  // Bytes carried by one bus beat
  localparam int BusWordBytes = 4;

endpackage

/* source/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
  input  logic                clk,
  input  logic                rstN,
  // Instruction cache side
  input  logic                iBusReq,
  input  memSysPkg::addrT     iBusAddr,
  output logic                iBusReady,
  // Data cache side
  input  logic                dBusReq,
  input  logic                dBusWrite,
  input  memSysPkg::addrT     dBusAddr,
  input  memSysPkg::byteMaskT dBusByteMask,
  output logic                dBusReady,
  // Shared memory bus
  output logic                hRequest,
  output logic                hWrite,
  output memSysPkg::addrT     hAddr,
  output memSysPkg::byteMaskT hByteMask,
  input  logic                hReady
);

  // Owner latched at the previous edge
  memSysPkg::arbStateT owner;
  // Owner for this cycle
  memSysPkg::arbStateT grant;

  // Owner keeps the bus while it requests, so a line fill is never split
  always_comb begin
    grant = owner;
    case (owner)
      memSysPkg::ownInstr: begin
        if (!iBusReq) begin
          grant = dBusReq ? memSysPkg::ownData : memSysPkg::ownNone;
        end
      end
      memSysPkg::ownData: begin
        if (!dBusReq) begin
          grant = iBusReq ? memSysPkg::ownInstr : memSysPkg::ownNone;
        end
      end
      default: begin
        // Free bus, data side wins a tie
        if (dBusReq) begin
          grant = memSysPkg::ownData;
        end else if (iBusReq) begin
          grant = memSysPkg::ownInstr;
        end else begin
          grant = memSysPkg::ownNone;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      owner <= memSysPkg::ownNone;
    end else begin
      owner <= grant;
    end
  end

  // Bus mux
  always_comb begin
    hRequest = 1'b0;
    hWrite = 1'b0;
    hAddr = dBusAddr;
    hByteMask = dBusByteMask;
    if (grant == memSysPkg::ownData) begin
      hRequest = dBusReq;
      hWrite = dBusWrite;
    end else if (grant == memSysPkg::ownInstr) begin
      hRequest = iBusReq;
      hAddr = iBusAddr;
      // Instruction side only reads
      hByteMask = '1;
    end
  end

  // Ready only goes back to the current owner
  assign iBusReady = hReady && (grant == memSysPkg::ownInstr);
  assign dBusReady = hReady && (grant == memSysPkg::ownData);

endmodule

/* source/busMemory.sv */
`timescale 1ns/1ps

module busMemory #(
  parameter int MemLatency = 2,
  parameter int MemWords = 1024
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                hRequest,
  input  logic                hWrite,
  input  memSysPkg::addrT     hAddr,
  input  memSysPkg::byteMaskT hByteMask,
  input  memSysPkg::wordT     hWData,
  output memSysPkg::wordT     hRData,
  output logic                hReady
);

  localparam int WordBits = $clog2(memSysPkg::BusWordBytes);
  localparam int MemIdxBits = $clog2(MemWords);
  localparam int CntBits = $clog2(MemLatency) + 1;

  typedef logic [MemIdxBits-1:0] memIdxT;
  typedef logic [CntBits-1:0] latCntT;

  memSysPkg::wordT mem [MemWords];

  memIdxT wordIdx;
  // Cycles the current request has been waiting
  latCntT latCnt;

  // Upper address bits alias, the memory just wraps
  assign wordIdx = hAddr[WordBits +: MemIdxBits];

  // Each word starts out as its own byte address with bit 31 inverted
  initial begin
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = (i * memSysPkg::BusWordBytes) ^ 32'h8000_0000;
    end
  end

  // Latency counter
  // Ready cycle doubles as the idle cycle, so one word costs MemLatency + 1
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      latCnt <= '0;
      hReady <= 1'b0;
    end else if (hReady) begin
      hReady <= 1'b0;
      latCnt <= '0;
    end else if (hRequest) begin
      if (latCnt == latCntT'(MemLatency - 1)) begin
        hReady <= 1'b1;
        latCnt <= '0;
      end else begin
        latCnt <= latCnt + 1'b1;
      end
    end else begin
      // Request withdrawn, start over next time
      latCnt <= '0;
    end
  end

  // Read data loaded together with ready, so it is valid in the ready cycle
  always_ff @(posedge clk) begin
    if (!hReady && hRequest && latCnt == latCntT'(MemLatency - 1)) begin
      hRData <= mem[wordIdx];
    end
  end

  // Stores land at the end of the ready cycle
  always_ff @(posedge clk) begin
    if (hReady && hRequest && hWrite) begin
      for (int b = 0; b < memSysPkg::BusWordBytes; b++) begin
        if (hByteMask[b]) begin
          mem[wordIdx][8*b +: 8] <= hWData[8*b +: 8];
        end
      end
    end
  end

endmodule

/* instrCache/instrCache.sv */
`timescale 1ns/1ps

module instrCache #(
  parameter int WordsPerLine = 4,
  parameter int NumLines = 16
) (
  input  logic             clk,
  input  logic             rstN,
  input  memSysPkg::addrT  pcF,
  output memSysPkg::wordT  instrF,
  output logic             iStall,
  output logic             busReq,
  output memSysPkg::addrT  busAddr,
  input  logic             busReady,
  input  memSysPkg::wordT  hRData
);

  // Address split: tag | line index | word in line | byte in word
  localparam int WordBits = $clog2(memSysPkg::BusWordBytes);
  localparam int OffBits = $clog2(WordsPerLine);
  localparam int IdxBits = $clog2(NumLines);
  localparam int TagBits = 32 - IdxBits - OffBits - WordBits;

  typedef logic [TagBits-1:0] tagT;
  typedef logic [IdxBits-1:0] lineIdxT;
  typedef logic [OffBits-1:0] wordSelT;

  // Per-line storage
  tagT             tagMem [NumLines];
  logic            validBits [NumLines];
  memSysPkg::wordT dataMem [NumLines][WordsPerLine];

  // Fields of the current fetch address
  tagT     pcTag;
  lineIdxT pcIdx;
  wordSelT pcWord;

  // Next word of the line to be filled
  wordSelT fillCnt;

  logic hit;

  assign pcTag = pcF[31 -: TagBits];
  assign pcIdx = pcF[WordBits+OffBits +: IdxBits];
  assign pcWord = pcF[WordBits +: OffBits];

  // Lookup is purely combinational so a hit returns in the same cycle
  assign hit = validBits[pcIdx] && (tagMem[pcIdx] == pcTag);
  assign instrF = dataMem[pcIdx][pcWord];
  assign iStall = !hit;

  // A miss keeps the request up for the whole line
  assign busReq = !hit;
  // Fill always walks the line from word 0 upwards
  assign busAddr = {pcTag, pcIdx, fillCnt, {WordBits{1'b0}}};

  // Word counter and valid bits
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fillCnt <= '0;
      for (int i = 0; i < NumLines; i++) begin
        validBits[i] <= 1'b0;
      end
    end else if (busReady) begin
      // Counter wraps back to 0 after the last word
      fillCnt <= fillCnt + 1'b1;
      if (&fillCnt) begin
        validBits[pcIdx] <= 1'b1;
      end
    end
  end

  // Line data and tag
  always_ff @(posedge clk) begin
    if (busReady) begin
      dataMem[pcIdx][fillCnt] <= hRData;
      // Tag goes in with the last word, the line turns valid at the same edge
      if (&fillCnt) begin
        tagMem[pcIdx] <= pcTag;
      end
    end
  end

endmodule

/* dataCache/dataCache.sv */
`timescale 1ns/1ps

module dataCache #(
  parameter int WordsPerLine = 4,
  parameter int NumLines = 16
) (
  input  logic               clk,
  input  logic               rstN,
  input  logic               memWriteM,
  input  logic               memtoRegM,
  input  memSysPkg::addrT    dataAdrM,
  input  memSysPkg::wordT    writeDataM,
  input  memSysPkg::byteMaskT byteMaskM,
  output memSysPkg::wordT    readDataM,
  output logic               dStall,
  output logic               busReq,
  output logic               busWrite,
  output memSysPkg::addrT    busAddr,
  output memSysPkg::byteMaskT busByteMask,
  output memSysPkg::wordT    hWData,
  input  logic               busReady,
  input  memSysPkg::wordT    hRData
);

  localparam int WordBits = $clog2(memSysPkg::BusWordBytes);
  localparam int OffBits = $clog2(WordsPerLine);
  localparam int IdxBits = $clog2(NumLines);
  localparam int TagBits = 32 - IdxBits - OffBits - WordBits;

  typedef logic [TagBits-1:0] tagT;
  typedef logic [IdxBits-1:0] lineIdxT;
  typedef logic [OffBits-1:0] wordSelT;

  tagT             tagMem [NumLines];
  logic            validBits [NumLines];
  memSysPkg::wordT dataMem [NumLines][WordsPerLine];

  tagT     adrTag;
  lineIdxT adrIdx;
  wordSelT adrWord;

  // Word of the line the fill is waiting for
  wordSelT fillCnt;

  logic hit;
  // Load miss, line is being brought in
  logic fillActive;

  assign adrTag = dataAdrM[31 -: TagBits];
  assign adrIdx = dataAdrM[WordBits+OffBits +: IdxBits];
  assign adrWord = dataAdrM[WordBits +: OffBits];

  assign hit = validBits[adrIdx] && (tagMem[adrIdx] == adrTag);
  assign readDataM = dataMem[adrIdx][adrWord];

  // A store takes priority if both strobes are up
  assign fillActive = memtoRegM && !memWriteM && !hit;

  // Store stall ends in the cycle its bus word completes
  assign dStall = fillActive || (memWriteM && !busReady);

  // Write-through: every store is one bus word, hit or miss
  assign busReq = memWriteM || fillActive;
  assign busWrite = memWriteM;
  assign hWData = writeDataM;
  assign busByteMask = memWriteM ? byteMaskM : '1;

  always_comb begin
    if (memWriteM) begin
      busAddr = {dataAdrM[31:WordBits], {WordBits{1'b0}}};
    end else begin
      // Fill starts at word 0 and steps one word per ready
      busAddr = {adrTag, adrIdx, fillCnt, {WordBits{1'b0}}};
    end
  end

  // Control state
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fillCnt <= '0;
      for (int i = 0; i < NumLines; i++) begin
        validBits[i] <= 1'b0;
      end
    end else if (busReady && fillActive) begin
      fillCnt <= fillCnt + 1'b1;
      if (&fillCnt) begin
        validBits[adrIdx] <= 1'b1;
      end
    end
  end

  // Line storage, updated by fill words and by store hits
  always_ff @(posedge clk) begin
    if (busReady && fillActive) begin
      dataMem[adrIdx][fillCnt] <= hRData;
      if (&fillCnt) begin
        tagMem[adrIdx] <= adrTag;
      end
    end else if (busReady && memWriteM && hit) begin
      // Merge only the enabled lanes into the cached copy
      for (int b = 0; b < memSysPkg::BusWordBytes; b++) begin
        if (byteMaskM[b]) begin
          dataMem[adrIdx][adrWord][8*b +: 8] <= writeDataM[8*b +: 8];
        end
      end
    end
    // Store miss leaves the cache alone, no allocate
  end

endmodule

/* source/memSystemTop.sv */
`timescale 1ns/1ps

module memSystemTop #(
  parameter int WordsPerLine = 4,
  parameter int NumLines = 16,
  parameter int MemLatency = 2,
  parameter int MemWords = 1024
) (
  input  logic                clk,
  input  logic                rstN,
  // Fetch port
  input  memSysPkg::addrT     pcF,
  output memSysPkg::wordT     instrF,
  output logic                iStall,
  // Load/store port
  input  logic                memWriteM,
  input  logic                memtoRegM,
  input  memSysPkg::addrT     dataAdrM,
  input  memSysPkg::wordT     writeDataM,
  input  memSysPkg::byteMaskT byteMaskM,
  output memSysPkg::wordT     readDataM,
  output logic                dStall
);

  // Instruction cache to arbiter
  logic                iBusReq;
  logic                iBusReady;
  memSysPkg::addrT     iBusAddr;

  // Data cache to arbiter
  logic                dBusReq;
  logic                dBusWrite;
  logic                dBusReady;
  memSysPkg::addrT     dBusAddr;
  memSysPkg::byteMaskT dBusByteMask;

  // Shared bus, write data skips the arbiter
  logic                hRequest;
  logic                hWrite;
  logic                hReady;
  memSysPkg::addrT     hAddr;
  memSysPkg::byteMaskT hByteMask;
  memSysPkg::wordT     hWData;
  memSysPkg::wordT     hRData;

  instrCache #(.WordsPerLine(WordsPerLine), .NumLines(NumLines)) iCache (
    .clk(clk), .rstN(rstN), .pcF(pcF), .instrF(instrF), .iStall(iStall),
    .busReq(iBusReq), .busAddr(iBusAddr), .busReady(iBusReady), .hRData(hRData)
  );

  dataCache #(.WordsPerLine(WordsPerLine), .NumLines(NumLines)) dCache (
    .clk(clk), .rstN(rstN), .memWriteM(memWriteM), .memtoRegM(memtoRegM),
    .dataAdrM(dataAdrM), .writeDataM(writeDataM), .byteMaskM(byteMaskM),
    .readDataM(readDataM), .dStall(dStall), .busReq(dBusReq), .busWrite(dBusWrite),
    .busAddr(dBusAddr), .busByteMask(dBusByteMask), .hWData(hWData),
    .busReady(dBusReady), .hRData(hRData)
  );

  busArbiter arbiter (
    .clk(clk), .rstN(rstN),
    .iBusReq(iBusReq), .iBusAddr(iBusAddr), .iBusReady(iBusReady),
    .dBusReq(dBusReq), .dBusWrite(dBusWrite), .dBusAddr(dBusAddr),
    .dBusByteMask(dBusByteMask), .dBusReady(dBusReady),
    .hRequest(hRequest), .hWrite(hWrite), .hAddr(hAddr), .hByteMask(hByteMask),
    .hReady(hReady)
  );

  // Fixed-latency memory behind the bus
  busMemory #(.MemLatency(MemLatency), .MemWords(MemWords)) memory (
    .clk(clk), .rstN(rstN), .hRequest(hRequest), .hWrite(hWrite), .hAddr(hAddr),
    .hByteMask(hByteMask), .hWData(hWData), .hRData(hRData), .hReady(hReady)
  );

endmodule

/* verification/memSystem_properties.sv */
`timescale 1ns/1ps

module memSystemProperties #(
  parameter int WordsPerLine = 4,
  parameter int MemLatency = 2
) (
  input logic                clk,
  input logic                rstN,
  input logic                hRequest,
  input logic                hWrite,
  input memSysPkg::addrT     hAddr,
  input memSysPkg::byteMaskT hByteMask,
  input memSysPkg::wordT     hWData,
  input logic                hReady,
  input logic                iBusReady,
  input logic                dBusReady,
  input logic                iStall,
  input logic                dStall
);

  // Two back-to-back line fills, the longest wait a cache can see
  localparam int StallLimit = 2 * WordsPerLine * (MemLatency + 1);

  // Cycles each stall has been high so far
  int iStallLen;
  int dStallLen;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      iStallLen <= 0;
      dStallLen <= 0;
    end else begin
      iStallLen <= iStall ? iStallLen + 1 : 0;
      dStallLen <= dStall ? dStallLen + 1 : 0;
    end
  end

  // Word stays on the bus until the memory answers
  assert property (@(posedge clk) disable iff (!rstN)
    hRequest && !hReady |=> hRequest && $stable(hAddr) && $stable(hWrite)
      && $stable(hByteMask))
    else $error("bus request changed or dropped before hReady");

  // Write data only matters on a write
  assert property (@(posedge clk) disable iff (!rstN)
    hRequest && hWrite && !hReady |=> $stable(hWData))
    else $error("write data changed before hReady");

  assert property (@(posedge clk) disable iff (!rstN)
    $rose(hReady) |-> $past(hRequest))
    else $error("hReady rose with no request pending");

  // Every ready reaches exactly one owner, never both and never none
  assert property (@(posedge clk) disable iff (!rstN)
    hReady |-> (iBusReady ^ dBusReady))
    else $error("hReady not returned to exactly one cache");

  assert property (@(posedge clk) disable iff (!rstN) iStallLen <= StallLimit)
    else $error("iStall high longer than two line fills");

  assert property (@(posedge clk) disable iff (!rstN) dStallLen <= StallLimit)
    else $error("dStall high longer than two line fills");

endmodule

bind memSystemTop memSystemProperties #(
  .WordsPerLine(WordsPerLine),
  .MemLatency(MemLatency)
) props (
  .clk(clk), .rstN(rstN), .hRequest(hRequest), .hWrite(hWrite), .hAddr(hAddr),
  .hByteMask(hByteMask), .hWData(hWData), .hReady(hReady),
  .iBusReady(iBusReady), .dBusReady(dBusReady), .iStall(iStall), .dStall(dStall)
);

/* verification/memSystemTb.sv */
`timescale 1ns/1ps

module memSystemTb;

  localparam int WordsPerLine = 4;
  localparam int NumLines = 16;
  localparam int MemLatency = 2;
  localparam int MemWords = 1024;
  localparam int ClkPeriod = 40;
  localparam int ResetCycles = 10;
  localparam int RandomOps = 300;
  localparam int DirectedOps = 13;
  localparam int NumOps = RandomOps + DirectedOps;
  // Four uncontended line fills per operation
  localparam int TimeoutCycles = 4 * NumOps * WordsPerLine * (MemLatency + 1);
  // Top bit of the word index into the shadow memory
  localparam int IdxMsb = $clog2(MemWords) + 1;
  // Fetches and data accesses never touch the same words
  localparam logic [31:0] CodeBase = 32'h0000_0000;
  localparam logic [31:0] DataBase = 32'h0000_0800;

  logic                clk;
  logic                rstN;
  memSysPkg::addrT     pcF;
  memSysPkg::wordT     instrF;
  logic                iStall;
  logic                memWriteM;
  logic                memtoRegM;
  memSysPkg::addrT     dataAdrM;
  memSysPkg::wordT     writeDataM;
  memSysPkg::byteMaskT byteMaskM;
  memSysPkg::wordT     readDataM;
  logic                dStall;

  // Expected memory contents, one entry per bus word
  memSysPkg::wordT shadow [MemWords];
  int cycleCount = 0;

  memSystemTop #(
    .WordsPerLine(WordsPerLine), .NumLines(NumLines),
    .MemLatency(MemLatency), .MemWords(MemWords)
  ) DUT (
    .clk(clk), .rstN(rstN), .pcF(pcF), .instrF(instrF), .iStall(iStall),
    .memWriteM(memWriteM), .memtoRegM(memtoRegM), .dataAdrM(dataAdrM),
    .writeDataM(writeDataM), .byteMaskM(byteMaskM), .readDataM(readDataM),
    .dStall(dStall)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod/2) clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      abortRun($sformatf("timeout: run still busy after %0d cycles", TimeoutCycles));
    end
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkWord(input string testName, input memSysPkg::wordT expected,
                           input memSysPkg::wordT actual);
    assert (actual === expected) else begin
      abortRun($sformatf("mismatch in %s: expected 0x%h, actual 0x%h",
                         testName, expected, actual));
    end
  endtask

  // Only the lanes enabled in the mask take the new bytes
  function automatic memSysPkg::wordT mergeBytes(input memSysPkg::wordT oldWord,
      input memSysPkg::wordT newWord, input memSysPkg::byteMaskT mask);
    memSysPkg::wordT result;
    result = oldWord;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        result[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return result;
  endfunction

  // Two 32-word blocks 256 bytes apart, so they fight over cache lines 0 to 7
  function automatic memSysPkg::addrT pickAddr(input memSysPkg::addrT base);
    logic [31:0] rnd;
    rnd = $urandom;
    return base + {23'b0, rnd[5], 1'b0, rnd[4:0], 2'b00};
  endfunction

  function automatic memSysPkg::byteMaskT randomMask();
    logic [31:0] rnd;
    rnd = $urandom;
    // Empty mask would store nothing at all
    return (rnd[3:0] == 4'h0) ? 4'hF : rnd[3:0];
  endfunction

  // Polled in the low clock phase, DUT outputs are settled there
  task automatic waitStall(input bit dataSide, output bit stalled);
    #(ClkPeriod/4);
    stalled = dataSide ? dStall : iStall;
    while (dataSide ? dStall : iStall) begin
      @(negedge clk);
      #(ClkPeriod/4);
    end
  endtask

  task automatic fetchInstr(input string testName, input memSysPkg::addrT addr,
                            output bit missed);
    memSysPkg::wordT expected;
    expected = shadow[addr[IdxMsb:2]];
    pcF = addr;
    waitStall(1'b0, missed);
    checkWord(testName, expected, instrF);
    // Fetch is taken at the next rising edge
    @(negedge clk);
  endtask

  task automatic loadWord(input string testName, input memSysPkg::addrT addr,
                          output bit missed);
    memSysPkg::wordT expected;
    expected = shadow[addr[IdxMsb:2]];
    dataAdrM = addr;
    memtoRegM = 1'b1;
    waitStall(1'b1, missed);
    checkWord(testName, expected, readDataM);
    @(negedge clk);
    memtoRegM = 1'b0;
  endtask

  task automatic storeWord(input memSysPkg::addrT addr, input memSysPkg::wordT data,
                           input memSysPkg::byteMaskT mask);
    bit stalled;
    dataAdrM = addr;
    writeDataM = data;
    byteMaskM = mask;
    memWriteM = 1'b1;
    waitStall(1'b1, stalled);
    assert (stalled) else abortRun("store finished without waiting for its bus write");
    @(negedge clk);
    memWriteM = 1'b0;
    // Memory took the word at the rising edge just passed
    shadow[addr[IdxMsb:2]] = mergeBytes(shadow[addr[IdxMsb:2]], data, mask);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] wordAddr;
    bit missed;
    bit missedData;
    void'($urandom(44611));
    rstN = 1'b0;
    pcF = CodeBase + 32'h8;
    memWriteM = 1'b0;
    memtoRegM = 1'b0;
    dataAdrM = DataBase;
    writeDataM = '0;
    byteMaskM = '0;
    // Every word starts as its byte address with bit 31 flipped
    for (int i = 0; i < MemWords; i++) begin
      wordAddr = i * 4;
      shadow[i] = {~wordAddr[31], wordAddr[30:0]};
    end
    repeat (ResetCycles) @(negedge clk);
    rstN = 1'b1;

    // Cold fetch, then a neighbour in the same line
    fetchInstr("reset fetch", CodeBase + 32'h8, missed);
    assert (missed) else abortRun("fetch after reset hit an empty instruction cache");
    fetchInstr("same line fetch", CodeBase + 32'hC, missed);
    assert (!missed) else abortRun("fetch within a filled line stalled");

    loadWord("load miss", DataBase + 32'h10, missed);
    assert (missed) else abortRun("load after reset hit an empty data cache");
    loadWord("load hit", DataBase + 32'h18, missed);
    assert (!missed) else abortRun("load within a filled line stalled");

    // Store hit merges into the cached word
    storeWord(DataBase + 32'h14, $urandom, randomMask());
    loadWord("load after store hit", DataBase + 32'h14, missed);
    assert (!missed) else abortRun("load after a store hit missed the cache");
    // Store miss only reaches memory
    storeWord(DataBase + 32'h44, $urandom, randomMask());
    loadWord("load after store miss", DataBase + 32'h44, missed);
    assert (missed) else abortRun("store miss allocated a line in the data cache");

    // Both sides miss in the same cycle
    fork
      fetchInstr("parallel fetch", CodeBase + 32'h24, missed);
      loadWord("parallel load", DataBase + 32'h68, missedData);
    join
    assert (missed && missedData) else abortRun("parallel fetch and load did not both miss");
    fork
      fetchInstr("fetch beside store", CodeBase + 32'h130, missed);
      storeWord(DataBase + 32'h30, $urandom, randomMask());
    join
    loadWord("load after parallel store", DataBase + 32'h30, missed);

    for (int n = 0; n < RandomOps; n++) begin
      rnd = $urandom;
      case (rnd % 3)
        0: fetchInstr("random fetch", pickAddr(CodeBase), missed);
        1: loadWord("random load", pickAddr(DataBase), missed);
        default: storeWord(pickAddr(DataBase), $urandom, randomMask());
      endcase
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

/* sources.f */
common/memSysPkg.sv
source/busArbiter.sv
source/busMemory.sv
instrCache/instrCache.sv
dataCache/dataCache.sv
source/memSystemTop.sv
verification/memSystem_properties.sv
verification/memSystemTb.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f sources.f \
    --top-module memSystemTb -o memSystemSim &&
  ./obj_dir/memSystemSim ||
  { echo "Simulation failed"; exit 1; }
